// ==== hw/pwm_map_pkg.sv ====
// Register map and control word layout of the PWM generator, imported by the sequencer and generator
package pwm_map_pkg;

    // Field view of the control register
    typedef struct packed {
        logic [28:0] reserved;
        logic        centre_mode;
        logic        output_enable;
        logic        counter_enable;
    } pwm_control_fields_t;

    // The bus carries the raw word and the generator reads it back through the fields
    typedef union packed {
        logic [31:0]         raw;
        pwm_control_fields_t fields;
    } pwm_control_t;

    // Byte offsets from the generator base address
    localparam logic [31:0] ctrl_offset       = 32'h000;
    localparam logic [31:0] compare_low_base  = 32'h100;
    localparam logic [31:0] compare_high_base = 32'h110;
    localparam logic [31:0] period_offset     = 32'h134;
    localparam logic [31:0] prescale_offset   = 32'h13c;
    localparam logic [31:0] polarity_offset   = 32'h144;

    // Control words for a running and a halted modulator
    localparam pwm_control_t modulator_on_word = pwm_control_fields_t'{
        reserved: '0, centre_mode: 1'b1, output_enable: 1'b1, counter_enable: 1'b1
    };
    localparam pwm_control_t modulator_off_word = pwm_control_fields_t'{
        reserved: '0, centre_mode: 1'b1, output_enable: 1'b0, counter_enable: 1'b0
    };

    // Configuration words for counting on every clock with outputs active high
    localparam logic [31:0] prescale_word = 32'h0;
    localparam logic [31:0] polarity_word = 32'h0;

endpackage

// ==== hw/vsi_types_pkg.sv ====
// Bus and compare types passed between the modulation blocks of the inverter subsystem
package vsi_types_pkg;

    // One register write towards the PWM generator
    typedef struct packed {
        logic [31:0] dest;
        logic [31:0] data;
        logic        valid;
    } write_request_t;

    // Centred switching instants of one phase leg within a PWM period
    typedef struct packed {
        logic [15:0] low;
        logic [15:0] high;
    } compare_pair_t;

endpackage

// ==== hw/compare_calculator.sv ====
// Two-stage pipeline turning a PWM period and per-phase duties into centred compare pairs
`timescale 1ns/1ps

module compare_calculator #(
    parameter int n_phases = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         calculate,
    input  logic [15:0]                  period,
    input  logic [15:0]                  duty [n_phases],
    output vsi_types_pkg::compare_pair_t compares [n_phases],
    output logic                         calc_done
);

    logic        stage_valid;
    logic [15:0] half_period;
    logic [15:0] half_duty [n_phases];

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage_valid <= 1'b0;
            calc_done   <= 1'b0;
        end else begin
            stage_valid <= calculate;
            calc_done   <= stage_valid;
        end
    end

    // Stage one clamps the duty to the period before halving
    always_ff @(posedge clock) begin
        if (calculate) begin
            half_period <= period >> 1;
            for (int i = 0; i < n_phases; i++) begin
                half_duty[i] <= ((duty[i] > period) ? period : duty[i]) >> 1;
            end
        end
    end

    // Stage two places the on-time symmetrically around mid-period
    always_ff @(posedge clock) begin
        if (stage_valid) begin
            for (int i = 0; i < n_phases; i++) begin
                compares[i].low  <= half_period - half_duty[i];
                compares[i].high <= half_period + half_duty[i];
            end
        end
    end

    // Relies on the stage one clamp keeping the half duty within the half period
    for (genvar i = 0; i < n_phases; i++) begin : g_order_check
        assert property (@(posedge clock) disable iff (!reset)
            calc_done |-> compares[i].low <= compares[i].high)
            else $error("phase %0d low compare above high compare", i);
    end

endmodule

// ==== hw/pre_modulation_sequencer.sv ====
// FSM that issues configuration, start/stop and compare update writes to the PWM generator
`timescale 1ns/1ps

module pre_modulation_sequencer #(
    parameter int          n_phases      = 4,
    parameter logic [31:0] pwm_base_addr = 32'h0
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          configure,
    input  logic                          start,
    input  logic                          stop,
    input  logic [n_phases-1:0]           update,
    input  logic [15:0]                   period,
    input  vsi_types_pkg::compare_pair_t  compares [n_phases],
    input  logic                          calc_done,
    input  logic                          ready,
    output logic                          calculate,
    output logic                          done,
    output logic                          modulator_status,
    output vsi_types_pkg::write_request_t write_request
);

    import pwm_map_pkg::*;
    import vsi_types_pkg::*;

    localparam int n_updates = 2 * n_phases + 1;
    localparam int idx_w     = $clog2(n_updates);

    // Configuration burst in the order it is written
    localparam logic [31:0] config_addr [3] = '{prescale_offset, polarity_offset, ctrl_offset};
    localparam logic [31:0] config_data [3] = '{prescale_word, polarity_word,
                                                modulator_off_word.raw};

    typedef enum logic [1:0] {
        idle,
        configuration,
        write_gap,
        update_modulator
    } state_t;

    state_t           state;
    state_t           return_state;
    logic [idx_w-1:0] index;
    logic             update_pending;
    logic             compares_ready;
    logic [15:0]      period_latched;
    compare_pair_t    compares_latched [n_phases];
    logic [31:0]      update_addr [n_updates];
    logic [15:0]      update_data [n_updates];

    // Update burst is the period first, then all low compares, then all high compares
    always_comb begin
        update_addr[0] = period_offset;
        update_data[0] = period_latched;
        for (int i = 0; i < n_phases; i++) begin
            update_addr[i + 1]            = compare_low_base + 32'(4 * i);
            update_data[i + 1]            = compares_latched[i].low;
            update_addr[i + 1 + n_phases] = compare_high_base + 32'(4 * i);
            update_data[i + 1 + n_phases] = compares_latched[i].high;
        end
    end

    // The period is sampled on the same edge as the calculator's first stage
    always_ff @(posedge clock) begin
        if (calculate) begin
            period_latched <= period;
        end
        if (calc_done) begin
            compares_latched <= compares;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state            <= idle;
            return_state     <= idle;
            index            <= '0;
            update_pending   <= 1'b0;
            compares_ready   <= 1'b0;
            calculate        <= 1'b0;
            done             <= 1'b0;
            modulator_status <= 1'b0;
            write_request    <= '0;
        end else begin
            calculate      <= 1'b0;
            done           <= 1'b0;
            update_pending <= update_pending | (|update);
            if (calc_done) begin
                compares_ready <= 1'b1;
            end

            case (state)
                idle: begin
                    if (configure) begin
                        index <= '0;
                        state <= configuration;
                    end else if (start || stop) begin
                        modulator_status    <= start;
                        write_request.dest  <= pwm_base_addr + ctrl_offset;
                        write_request.data  <= start ? modulator_on_word.raw
                                                     : modulator_off_word.raw;
                        write_request.valid <= 1'b1;
                        return_state        <= idle;
                        state               <= write_gap;
                    end else if (compares_ready && !modulator_status) begin
                        // A result landing this very cycle still needs its own burst
                        compares_ready <= calc_done;
                        index          <= '0;
                        state          <= update_modulator;
                    end else if (update_pending && !modulator_status) begin
                        calculate      <= 1'b1;
                        update_pending <= |update;
                    end
                end

                configuration: begin
                    write_request.dest  <= pwm_base_addr + config_addr[index[1:0]];
                    write_request.data  <= config_data[index[1:0]];
                    write_request.valid <= 1'b1;
                    return_state        <= configuration;
                    state               <= write_gap;
                end

                update_modulator: begin
                    write_request.dest  <= pwm_base_addr + update_addr[index];
                    write_request.data  <= 32'(update_data[index]);
                    write_request.valid <= 1'b1;
                    return_state        <= update_modulator;
                    state               <= write_gap;
                end

                write_gap: begin
                    // The request is held until the generator takes it
                    if (ready) begin
                        write_request.valid <= 1'b0;
                        index               <= index + 1'b1;
                        if (return_state == configuration && index == idx_w'(2)) begin
                            done  <= 1'b1;
                            state <= idle;
                        end else if (return_state == update_modulator
                                     && index == idx_w'(n_updates - 1)) begin
                            state <= idle;
                        end else begin
                            state <= return_state;
                        end
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // The generator only stalls in the gap cycle, so a request never stays up
    assert property (@(posedge clock) disable iff (!reset)
        write_request.valid |=> !write_request.valid)
        else $error("write request valid in two consecutive cycles");

    assert property (@(posedge clock) disable iff (!reset)
        write_request.valid && return_state == update_modulator |-> !modulator_status)
        else $error("compare update written while the modulator runs");

endmodule

// ==== hw/pwm_generator.sv ====
// PWM generator with bus-written register file, period counter and centre-aligned phase outputs
`timescale 1ns/1ps

module pwm_generator #(
    parameter int          n_phases      = 4,
    parameter logic [31:0] pwm_base_addr = 32'h0
) (
    input  logic                          clock,
    input  logic                          reset,
    input  vsi_types_pkg::write_request_t write_request,
    output logic                          ready,
    output logic [n_phases-1:0]           pwm_out
);

    import pwm_map_pkg::*;
    import vsi_types_pkg::*;

    logic [31:0]         offset;
    logic                write_accept;
    logic                offset_known;
    logic                apply_control;
    pwm_control_t        control;
    pwm_control_t        control_staged;
    logic [15:0]         period_reg;
    logic [15:0]         prescale_reg;
    logic [15:0]         prescale_count;
    logic [15:0]         counter;
    logic [n_phases-1:0] polarity;
    logic [n_phases-1:0] in_window;
    compare_pair_t       compare_reg [n_phases];

    assign offset       = write_request.dest - pwm_base_addr;
    assign ready        = !apply_control;
    assign write_accept = write_request.valid && ready;

    always_comb begin
        offset_known = offset inside {ctrl_offset, period_offset, prescale_offset,
                                      polarity_offset};
        for (int i = 0; i < n_phases; i++) begin
            if (offset == compare_low_base + 32'(4 * i)
                || offset == compare_high_base + 32'(4 * i)) begin
                offset_known = 1'b1;
            end
        end
    end

    // A control word is staged on the write and takes effect one cycle later
    always_ff @(posedge clock) begin
        if (!reset) begin
            apply_control <= 1'b0;
            control       <= modulator_off_word;
            prescale_reg  <= '0;
            polarity      <= '0;
        end else begin
            apply_control <= write_accept && offset == ctrl_offset;
            if (apply_control) begin
                control <= control_staged;
            end
            if (write_accept && offset == prescale_offset) begin
                prescale_reg <= write_request.data[15:0];
            end
            if (write_accept && offset == polarity_offset) begin
                polarity <= write_request.data[n_phases-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_accept) begin
            if (offset == ctrl_offset) begin
                control_staged.raw <= write_request.data;
            end
            if (offset == period_offset) begin
                period_reg <= write_request.data[15:0];
            end
            for (int i = 0; i < n_phases; i++) begin
                if (offset == compare_low_base + 32'(4 * i)) begin
                    compare_reg[i].low <= write_request.data[15:0];
                end
                if (offset == compare_high_base + 32'(4 * i)) begin
                    compare_reg[i].high <= write_request.data[15:0];
                end
            end
        end
    end

    // Counter advances once per prescaler tick and wraps at period minus one
    always_ff @(posedge clock) begin
        if (!reset || !control.fields.counter_enable) begin
            counter        <= '0;
            prescale_count <= '0;
        end else if (prescale_count >= prescale_reg) begin
            prescale_count <= '0;
            counter        <= (counter >= period_reg - 16'd1) ? '0 : counter + 16'd1;
        end else begin
            prescale_count <= prescale_count + 16'd1;
        end
    end

    // The window opens at the low compare and closes at the high compare
    always_comb begin
        for (int i = 0; i < n_phases; i++) begin
            in_window[i] = counter >= compare_reg[i].low && counter < compare_reg[i].high;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= '0;
        end else begin
            pwm_out <= {n_phases{control.fields.output_enable}} & (in_window ^ polarity);
        end
    end

    assert property (@(posedge clock) disable iff (!reset) write_accept |-> offset_known)
        else $error("write to unmapped offset %h ignored", offset);

endmodule

// ==== hw/vsi_modulator_top.sv ====
// Top level of the inverter modulator, joining sequencer, compare calculator and PWM generator
`timescale 1ns/1ps

module vsi_modulator_top #(
    parameter int          n_phases      = 4,
    parameter logic [31:0] pwm_base_addr = 32'h4000_0000
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                configure,
    input  logic                start,
    input  logic                stop,
    input  logic [n_phases-1:0] update,
    input  logic [15:0]         period,
    input  logic [15:0]         duty [n_phases],
    output logic                done,
    output logic                modulator_status,
    output logic [n_phases-1:0] pwm_out
);

    import vsi_types_pkg::*;

    logic           calculate;
    logic           calc_done;
    logic           ready;
    compare_pair_t  compares [n_phases];
    write_request_t write_request;

    compare_calculator #(
        .n_phases (n_phases)
    ) compare_calculator_inst (
        .clock     (clock),
        .reset     (reset),
        .calculate (calculate),
        .period    (period),
        .duty      (duty),
        .compares  (compares),
        .calc_done (calc_done)
    );

    pre_modulation_sequencer #(
        .n_phases      (n_phases),
        .pwm_base_addr (pwm_base_addr)
    ) pre_modulation_sequencer_inst (
        .clock            (clock),
        .reset            (reset),
        .configure        (configure),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .period           (period),
        .compares         (compares),
        .calc_done        (calc_done),
        .ready            (ready),
        .calculate        (calculate),
        .done             (done),
        .modulator_status (modulator_status),
        .write_request    (write_request)
    );

    pwm_generator #(
        .n_phases      (n_phases),
        .pwm_base_addr (pwm_base_addr)
    ) pwm_generator_inst (
        .clock         (clock),
        .reset         (reset),
        .write_request (write_request),
        .ready         (ready),
        .pwm_out       (pwm_out)
    );

endmodule

// ==== dv/pwm_model.svh ====
// Reference model of centred compare values and per-period high counts, included by the testbench
`ifndef PWM_MODEL_SVH
`define PWM_MODEL_SVH

// A duty above the period is limited to the full period
function automatic int clamped_duty(input int period_value, input int duty_value);
    if (duty_value > period_value) begin
        return period_value;
    end
    return duty_value;
endfunction

// Low compare sits half the duty before mid-period with both halves rounded down
function automatic int model_low(input int period_value, input int duty_value);
    return period_value / 2 - clamped_duty(period_value, duty_value) / 2;
endfunction

function automatic int model_high(input int period_value, input int duty_value);
    return period_value / 2 + clamped_duty(period_value, duty_value) / 2;
endfunction

// The output is high for counter values from low up to but not including high
function automatic int model_high_count(input int period_value, input int duty_value);
    return model_high(period_value, duty_value) - model_low(period_value, duty_value);
endfunction

`endif

// ==== dv/vsi_modulator_tb.sv ====
// Testbench for the inverter modulator; drives random operating points and checks PWM on-times
`timescale 1ns/1ps

module vsi_modulator_tb;

    localparam int n_phases   = 4;
    localparam int n_loops    = 20;
    localparam int max_period = 200;
    // Each loop measures three windows of one period plus bounded bus and settling time
    localparam int loop_cycles     = 3 * max_period + 300;
    localparam int watchdog_cycles = n_loops * loop_cycles + 500;

    logic                clock;
    logic                reset;
    logic                configure;
    logic                start;
    logic                stop;
    logic [n_phases-1:0] update;
    logic [15:0]         period;
    logic [15:0]         duty [n_phases];
    logic                done;
    logic                modulator_status;
    logic [n_phases-1:0] pwm_out;
    logic                sequencer_busy;
    logic [15:0]         lfsr_state;

    int check_count;
    int mismatch_count;
    int failure_count;
    int period_value;
    int duty_value [n_phases];
    int applied_duty [n_phases];
    int high_count [n_phases];

    `include "pwm_model.svh"

    vsi_modulator_top #(
        .n_phases (n_phases)
    ) vsi_modulator_top_inst (
        .clock            (clock),
        .reset            (reset),
        .configure        (configure),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .period           (period),
        .duty             (duty),
        .done             (done),
        .modulator_status (modulator_status),
        .pwm_out          (pwm_out)
    );

    // Busy covers the calculator pipeline as well as the sequencer's own flags and FSM
    assign sequencer_busy = vsi_modulator_top_inst.pre_modulation_sequencer_inst.update_pending
        || vsi_modulator_top_inst.pre_modulation_sequencer_inst.compares_ready
        || vsi_modulator_top_inst.pre_modulation_sequencer_inst.calculate
        || vsi_modulator_top_inst.compare_calculator_inst.stage_valid
        || vsi_modulator_top_inst.calc_done
        || vsi_modulator_top_inst.pre_modulation_sequencer_inst.state != 2'd0;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, failure_count);
        $display("Checks failed");
        $finish;
    end

    // Inputs change and outputs are sampled 2 ns after each rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic int random_bits(input int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic check_value(input string test_name, input int expected, input int actual);
        check_count++;
        assert (actual == expected)
            else begin
                mismatch_count++;
                $display("mismatch %s: expected %0d, actual %0d", test_name, expected, actual);
            end
    endtask

    task automatic require(input logic condition, input string test_name, input string problem);
        check_count++;
        assert (condition)
            else begin
                failure_count++;
                $display("%s: %s", test_name, problem);
            end
    endtask

    task automatic wait_sequencer_idle(input string test_name);
        int cycles;
        cycles = 0;
        while (sequencer_busy && cycles < 100) begin
            next_cycle();
            cycles++;
        end
        require(!sequencer_busy, test_name, "sequencer did not return to idle within 100 cycles");
    endtask

    task automatic pulse_update();
        update = '1;
        next_cycle();
        update = '0;
    endtask

    task automatic switch_modulator(input logic turn_on, input string test_name);
        int cycles;
        start = turn_on;
        stop  = !turn_on;
        next_cycle();
        start  = 1'b0;
        stop   = 1'b0;
        cycles = 0;
        while (modulator_status != turn_on && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        require(modulator_status == turn_on, test_name, "modulator_status did not follow");
        // A stop also lets any pending compare update run to completion
        wait_sequencer_idle(test_name);
    endtask

    // One phase is forced above the period so the clamp is hit on every loop
    task automatic choose_duties(input int clamp_phase);
        for (int i = 0; i < n_phases; i++) begin
            if (i == clamp_phase) begin
                duty_value[i] = period_value + 1 + random_bits(6);
            end else begin
                duty_value[i] = random_bits(8);
            end
            duty[i] = 16'(duty_value[i]);
        end
    endtask

    task automatic check_compares(input string test_name);
        check_value({test_name, "_period"}, period_value,
                    int'(vsi_modulator_top_inst.pwm_generator_inst.period_reg));
        for (int i = 0; i < n_phases; i++) begin
            check_value({test_name, "_low"}, model_low(period_value, applied_duty[i]),
                        int'(vsi_modulator_top_inst.pwm_generator_inst.compare_reg[i].low));
            check_value({test_name, "_high"}, model_high(period_value, applied_duty[i]),
                        int'(vsi_modulator_top_inst.pwm_generator_inst.compare_reg[i].high));
        end
    endtask

    // The output repeats every period, so any window of one period gives the on-time
    task automatic measure_and_check(input string test_name);
        repeat (8) next_cycle();
        for (int i = 0; i < n_phases; i++) begin
            high_count[i] = 0;
        end
        for (int c = 0; c < period_value; c++) begin
            next_cycle();
            for (int i = 0; i < n_phases; i++) begin
                high_count[i] += int'(pwm_out[i]);
            end
        end
        for (int i = 0; i < n_phases; i++) begin
            check_value(test_name, model_high_count(period_value, applied_duty[i]),
                        high_count[i]);
        end
    endtask

    task automatic check_stopped_outputs();
        for (int c = 0; c < 16; c++) begin
            check_value("stop_status", 0, int'(modulator_status));
            check_value("stop_pwm", 0, int'(pwm_out));
            next_cycle();
        end
    endtask

    task automatic run_configure_test();
        int done_pulses;
        int first_done;
        done_pulses = 0;
        first_done  = 0;
        configure   = 1'b1;
        next_cycle();
        configure = 1'b0;
        for (int c = 1; c <= 20; c++) begin
            if (done) begin
                done_pulses++;
                if (first_done == 0) begin
                    first_done = c;
                end
            end
            check_value("configure_status", 0, int'(modulator_status));
            check_value("configure_pwm", 0, int'(pwm_out));
            next_cycle();
        end
        check_value("configure_done_pulses", 1, done_pulses);
        require(first_done != 0 && first_done <= 10, "configure",
                "done did not pulse within 10 cycles");
    endtask

    task automatic run_iteration();
        int clamp_phase;
        period_value = 16 + random_bits(8) % 185;
        period       = 16'(period_value);
        clamp_phase  = random_bits(2);
        choose_duties(clamp_phase);
        pulse_update();
        wait_sequencer_idle("update_off");
        applied_duty = duty_value;
        check_compares("update_off");
        switch_modulator(1'b1, "start");
        measure_and_check("update_off");
        check_value("clamp", 2 * (period_value / 2), high_count[clamp_phase]);

        // New duties while running stay pending until the modulator is stopped
        choose_duties(random_bits(2));
        pulse_update();
        measure_and_check("update_on_hold");
        switch_modulator(1'b0, "stop");
        applied_duty = duty_value;
        check_compares("update_after_stop");
        check_stopped_outputs();
        switch_modulator(1'b1, "restart");
        measure_and_check("update_applied");
        switch_modulator(1'b0, "final_stop");
    endtask

    initial begin
        lfsr_state     = 16'd21499;
        check_count    = 0;
        mismatch_count = 0;
        failure_count  = 0;
        reset          = 1'b0;
        configure      = 1'b0;
        start          = 1'b0;
        stop           = 1'b0;
        update         = '0;
        period         = 16'd0;
        for (int i = 0; i < n_phases; i++) begin
            duty[i] = 16'd0;
        end
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b1;

        run_configure_test();
        for (int iteration = 0; iteration < n_loops; iteration++) begin
            run_iteration();
        end

        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vsi_modulator.f ====
+incdir+dv
hw/pwm_map_pkg.sv
hw/vsi_types_pkg.sv
hw/compare_calculator.sv
hw/pre_modulation_sequencer.sv
hw/pwm_generator.sv
hw/vsi_modulator_top.sv
dv/vsi_modulator_tb.sv

// ==== Makefile ====
# Verilator build and run of the inverter modulator testbench
VERILATOR ?= verilator
TOP       ?= vsi_modulator_tb
FILE_LIST ?= vsi_modulator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: $(SIM)

# The binary is rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
